/* scan_io_macros.svh */
`ifndef SCAN_IO_MACROS_SVH
`define SCAN_IO_MACROS_SVH

// datapath widths
`define SCAN_COLOR_W        8
`define SCAN_CTRL_W         16
`define SCAN_KEY_W          2
`define SCAN_LED_W          8

// resync hold counter, reloads to all ones
`define SCAN_LED_CTR_W      10

// sys_ctrl bit positions
`define SCAN_HSYNC_POL_BIT  8
`define SCAN_VSYNC_POL_BIT  9
`define SCAN_FRAMELOCK_BIT  14

// osd overlay colours, rgb with red on top
`define SCAN_OSD_BLACK      24'h000000
`define SCAN_OSD_BLUE       24'h0000ff
`define SCAN_OSD_YELLOW     24'hffff00
`define SCAN_OSD_WHITE      24'hffffff

`endif

/* scan_io_pkg.sv */
`default_nettype none

`include "scan_io_macros.svh"

package scan_io_pkg;

    // one rgb pixel, red in the top byte
    typedef logic [3*`SCAN_COLOR_W-1:0] pixel_t;

    // host data word
    typedef logic [`SCAN_CTRL_W-1:0] ctrl_word_t;

    // overlay colour select from the osd generator
    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_t;

endpackage

`default_nettype wire

/* host_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scan_io_macros.svh"

module host_ctrl (
    input  wire                         clk27,
    input  wire                         sys_reset_n,
    input  wire                         req_i,
    input  wire                         we_i,
    input  wire                         addr_i,
    input  wire scan_io_pkg::ctrl_word_t wdata_i,
    input  wire [`SCAN_KEY_W-1:0]       key_sync_i,
    output logic                        ack_o,
    output scan_io_pkg::ctrl_word_t     rdata_o,
    output logic                        hsync_pol_o,
    output logic                        vsync_pol_o,
    output logic                        framelock_o
);
    import scan_io_pkg::*;

    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_ACKED = 1'b1
    } hs_state_t;

    hs_state_t  state;
    logic       req_q;      // sampled request
    logic       accept;
    ctrl_word_t sys_ctrl;
    ctrl_word_t controls;

    // controls word: keys in the low bits, zero above
    assign controls = {{(`SCAN_CTRL_W-`SCAN_KEY_W){1'b0}}, key_sync_i};

    assign accept = (state == ST_IDLE) && req_q;
    assign ack_o  = (state == ST_ACKED);

    // ========================================================================
    // four-phase handshake
    // ========================================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            req_q <= 1'b0;
            state <= ST_IDLE;
        end else begin
            req_q <= req_i;
            case (state)
                ST_IDLE:  if (req_q) state <= ST_ACKED;
                ST_ACKED: if (!req_q) state <= ST_IDLE;   // wait for host to drop req
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // sys_ctrl updates on the cycle ack rises
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            sys_ctrl <= '0;
        end else if (accept && we_i && !addr_i) begin
            sys_ctrl <= wdata_i;
        end
    end

    // read data, held while ack is high
    always_ff @(posedge clk27) begin
        if (accept && !we_i) begin
            rdata_o <= addr_i ? controls : sys_ctrl;
        end
    end

    // control fan-out
    assign hsync_pol_o = sys_ctrl[`SCAN_HSYNC_POL_BIT];
    assign vsync_pol_o = sys_ctrl[`SCAN_VSYNC_POL_BIT];
    assign framelock_o = sys_ctrl[`SCAN_FRAMELOCK_BIT];

endmodule

`default_nettype wire

/* input_sync.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scan_io_macros.svh"

module input_sync (
    input  wire                    clk27,
    input  wire                    sys_reset_n,
    input  wire [`SCAN_KEY_W-1:0]  key_i,
    input  wire                    hsync_i,
    input  wire                    vsync_i,
    input  wire                    fid_i,
    input  wire                    resync_strobe_i,
    input  wire                    hsync_pol_i,
    input  wire                    vsync_pol_i,
    output logic [`SCAN_KEY_W-1:0] key_sync_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   fid_o,
    output logic                   resync_pulse_o
);

    logic [`SCAN_KEY_W-1:0] key_sync1;
    logic [`SCAN_KEY_W-1:0] key_sync2;
    logic [1:0]             hsync_sync;     // [0] first flop, [1] second
    logic [1:0]             vsync_sync;
    logic [1:0]             fid_sync;
    logic [1:0]             resync_sync;
    logic                   resync_prev;

    // ========================================================================
    // two-flop synchronizers
    // ========================================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            key_sync1   <= '1;          // buttons are active low
            key_sync2   <= '1;
            hsync_sync  <= '0;
            vsync_sync  <= '0;
            fid_sync    <= '0;
            resync_sync <= '0;
            resync_prev <= 1'b0;
        end else begin
            key_sync1   <= key_i;
            key_sync2   <= key_sync1;
            hsync_sync  <= {hsync_sync[0], hsync_i};
            vsync_sync  <= {vsync_sync[0], vsync_i};
            fid_sync    <= {fid_sync[0], fid_i};
            resync_sync <= {resync_sync[0], resync_strobe_i};
            resync_prev <= resync_sync[1];
        end
    end

    // registered rising-edge pulse of the resync strobe
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            resync_pulse_o <= 1'b0;
        end else begin
            resync_pulse_o <= resync_sync[1] & ~resync_prev;
        end
    end

    assign key_sync_o = key_sync2;
    assign hsync_o    = hsync_sync[1] ^ hsync_pol_i;   // active high after polarity fix
    assign vsync_o    = vsync_sync[1] ^ vsync_pol_i;
    assign fid_o      = fid_sync[1];

endmodule

`default_nettype wire

/* led_status.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scan_io_macros.svh"

module led_status (
    input  wire                    clk27,
    input  wire                    sys_reset_n,
    input  wire                    resync_pulse_i,
    input  wire                    framelock_i,
    output logic [`SCAN_LED_W-1:0] led_o
);

    logic [`SCAN_LED_CTR_W-1:0] resync_led_ctr;
    logic                       resync_active;

    // ========================================================================
    // resync hold counter
    // ========================================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            resync_led_ctr <= '0;
        end else if (resync_pulse_i) begin
            resync_led_ctr <= {`SCAN_LED_CTR_W{1'b1}};   // restart hold
        end else if (resync_active) begin
            resync_led_ctr <= resync_led_ctr - 1'b1;
        end
    end

    assign resync_active = (resync_led_ctr != '0);

    // led word: framelock on top, no-ir-code flag, resync in the low bits.
    // the ir receiver is not part of this design so bit 3 stays lit
    assign led_o = {{4{framelock_i}}, 1'b1, {3{resync_active}}};

endmodule

`default_nettype wire

/* osd_mixer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scan_io_macros.svh"

module osd_mixer (
    input  wire                         clk27,
    input  wire                         sys_reset_n,
    input  wire scan_io_pkg::pixel_t    pix_i,
    input  wire                         hs_i,
    input  wire                         vs_i,
    input  wire                         de_i,
    input  wire                         osd_enable_i,
    input  wire scan_io_pkg::osd_color_t osd_color_i,
    output scan_io_pkg::pixel_t         pix_o,
    output logic                        hs_o,
    output logic                        vs_o,
    output logic                        de_o
);
    import scan_io_pkg::*;

    pixel_t osd_pix;
    pixel_t pix_s1;
    logic   hs_s1;
    logic   vs_s1;
    logic   de_s1;

    // overlay colour lookup
    always_comb begin
        case (osd_color_i)
            OSD_BLACK:  osd_pix = `SCAN_OSD_BLACK;
            OSD_BLUE:   osd_pix = `SCAN_OSD_BLUE;
            OSD_YELLOW: osd_pix = `SCAN_OSD_YELLOW;
            default:    osd_pix = `SCAN_OSD_WHITE;
        endcase
    end

    // ========================================================================
    // stage 1: overlay mux
    // ========================================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            pix_s1 <= '0;
            hs_s1  <= 1'b0;
            vs_s1  <= 1'b0;
            de_s1  <= 1'b0;
        end else begin
            pix_s1 <= osd_enable_i ? osd_pix : pix_i;
            hs_s1  <= hs_i;
            vs_s1  <= vs_i;
            de_s1  <= de_i;
        end
    end

    // ========================================================================
    // stage 2: output pin register
    // ========================================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            pix_o <= '0;
            hs_o  <= 1'b0;
            vs_o  <= 1'b0;
            de_o  <= 1'b0;
        end else begin
            pix_o <= pix_s1;
            hs_o  <= hs_s1;
            vs_o  <= vs_s1;
            de_o  <= de_s1;
        end
    end

endmodule

`default_nettype wire

/* scan_io_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scan_io_macros.svh"

module scan_io_top (
    input  wire                          clk27,
    input  wire                          sys_reset_n,
    // host register port
    input  wire                          req_i,
    input  wire                          we_i,
    input  wire                          addr_i,
    input  wire scan_io_pkg::ctrl_word_t wdata_i,
    output scan_io_pkg::ctrl_word_t      ack_rdata_unused_guard_o,
    output logic                         ack_o,
    output scan_io_pkg::ctrl_word_t      rdata_o,
    // buttons and digitizer syncs
    input  wire [`SCAN_KEY_W-1:0]        key_i,
    input  wire                          hsync_i,
    input  wire                          vsync_i,
    input  wire                          fid_i,
    input  wire                          resync_strobe_i,
    output logic                         hsync_o,
    output logic                         vsync_o,
    output logic                         fid_o,
    output logic [`SCAN_LED_W-1:0]       led_o,
    // pixel path
    input  wire scan_io_pkg::pixel_t     pix_i,
    input  wire                          hs_i,
    input  wire                          vs_i,
    input  wire                          de_i,
    input  wire                          osd_enable_i,
    input  wire scan_io_pkg::osd_color_t osd_color_i,
    output scan_io_pkg::pixel_t          tx_pix_o,
    output logic                         tx_hs_o,
    output logic                         tx_vs_o,
    output logic                         tx_de_o
);

    logic [`SCAN_KEY_W-1:0] key_sync;
    logic                   hsync_pol;
    logic                   vsync_pol;
    logic                   framelock;
    logic                   resync_pulse;

    // mirror of the read data for the board debug header
    assign ack_rdata_unused_guard_o = rdata_o;

    host_ctrl u_host_ctrl (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .key_sync_i  (key_sync),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .hsync_pol_o (hsync_pol),
        .vsync_pol_o (vsync_pol),
        .framelock_o (framelock)
    );

    input_sync u_input_sync (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .key_i           (key_i),
        .hsync_i         (hsync_i),
        .vsync_i         (vsync_i),
        .fid_i           (fid_i),
        .resync_strobe_i (resync_strobe_i),
        .hsync_pol_i     (hsync_pol),
        .vsync_pol_i     (vsync_pol),
        .key_sync_o      (key_sync),
        .hsync_o         (hsync_o),
        .vsync_o         (vsync_o),
        .fid_o           (fid_o),
        .resync_pulse_o  (resync_pulse)
    );

    led_status u_led_status (
        .clk27          (clk27),
        .sys_reset_n    (sys_reset_n),
        .resync_pulse_i (resync_pulse),
        .framelock_i    (framelock),
        .led_o          (led_o)
    );

    osd_mixer u_osd_mixer (
        .clk27        (clk27),
        .sys_reset_n  (sys_reset_n),
        .pix_i        (pix_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .de_i         (de_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .pix_o        (tx_pix_o),
        .hs_o         (tx_hs_o),
        .vs_o         (tx_vs_o),
        .de_o         (tx_de_o)
    );

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk27_o,
    output logic sys_reset_n_o
);

    // 27 MHz stand-in, 20 ns period
    initial begin
        clk27_o = 1'b0;
        forever #10 clk27_o = ~clk27_o;
    end

    initial begin
        sys_reset_n_o = 1'b0;
        repeat (2) @(posedge clk27_o);
        sys_reset_n_o <= 1'b1;      // release on a rising edge
    end

endmodule

`default_nettype wire

/* scan_io_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scan_io_macros.svh"

module scan_io_tb;
    import scan_io_pkg::*;

    logic                   clk27;
    logic                   sys_reset_n;
    logic                   req_i;
    logic                   we_i;
    logic                   addr_i;
    ctrl_word_t             wdata_i;
    ctrl_word_t             rdata_mirror;
    logic                   ack_o;
    ctrl_word_t             rdata_o;
    logic [`SCAN_KEY_W-1:0] key_i;
    logic                   hsync_i;
    logic                   vsync_i;
    logic                   fid_i;
    logic                   resync_strobe_i;
    logic                   hsync_o;
    logic                   vsync_o;
    logic                   fid_o;
    logic [`SCAN_LED_W-1:0] led_o;
    pixel_t                 pix_i;
    logic                   hs_i;
    logic                   vs_i;
    logic                   de_i;
    logic                   osd_enable_i;
    osd_color_t             osd_color_i;
    pixel_t                 tx_pix_o;
    logic                   tx_hs_o;
    logic                   tx_vs_o;
    logic                   tx_de_o;

    // reference model state
    logic [31:0]                seed = 32'h9b98_e5c4;
    ctrl_word_t                 model_sys_ctrl;
    logic [`SCAN_LED_CTR_W-1:0] model_ctr;
    logic [5:0]                 strobe_hist;    // [j] = strobe driven j edges ago
    pixel_t                     pix_q[$];       // 2-cycle video delay line
    logic [5:0]                 flag_q[$];      // hs, vs, de, hsync, vsync, fid
    int                         err_count;
    int                         check_count;
    int                         test_count;
    int                         test_fail_count;
    int                         test_err_base;

    tb_clock u_clock (
        .clk27_o       (clk27),
        .sys_reset_n_o (sys_reset_n)
    );

    scan_io_top dut_i (
        .clk27 (clk27), .sys_reset_n (sys_reset_n),
        .req_i (req_i), .we_i (we_i), .addr_i (addr_i), .wdata_i (wdata_i),
        .ack_rdata_unused_guard_o (rdata_mirror),
        .ack_o (ack_o), .rdata_o (rdata_o),
        .key_i (key_i), .hsync_i (hsync_i), .vsync_i (vsync_i), .fid_i (fid_i),
        .resync_strobe_i (resync_strobe_i),
        .hsync_o (hsync_o), .vsync_o (vsync_o), .fid_o (fid_o), .led_o (led_o),
        .pix_i (pix_i), .hs_i (hs_i), .vs_i (vs_i), .de_i (de_i),
        .osd_enable_i (osd_enable_i), .osd_color_i (osd_color_i),
        .tx_pix_o (tx_pix_o), .tx_hs_o (tx_hs_o), .tx_vs_o (tx_vs_o), .tx_de_o (tx_de_o)
    );

    // ========================================================================
    // random numbers, expected values and compares
    // ========================================================================
    function logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function pixel_t osd_rgb(input osd_color_t c);
        case (c)
            OSD_BLACK:  osd_rgb = `SCAN_OSD_BLACK;
            OSD_BLUE:   osd_rgb = `SCAN_OSD_BLUE;
            OSD_YELLOW: osd_rgb = `SCAN_OSD_YELLOW;
            default:    osd_rgb = `SCAN_OSD_WHITE;
        endcase
    endfunction

    // framelock x4, no-ir flag, resync x3
    function logic [`SCAN_LED_W-1:0] led_word(input logic framelock, input logic active);
        return {{4{framelock}}, 1'b1, {3{active}}};
    endfunction

    task check_pixel(input string name, input pixel_t got, input pixel_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task check_ctrl(input string name, input ctrl_word_t got, input ctrl_word_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task check_led(input string name, input logic [`SCAN_LED_W-1:0] got,
                   input logic [`SCAN_LED_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task abort_run(input string what);
        $display("error: %s", what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task end_test(input string name);
        test_count++;
        if (err_count == test_err_base) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            test_fail_count++;
            $display("test %0d %s: %0d errors", test_count, name, err_count - test_err_base);
        end
        test_err_base = err_count;
    endtask

    // counts negedges until ack_o reaches level
    task wait_ack(input logic level, output int cycles);
        cycles = 0;
        @(negedge clk27);
        while (ack_o !== level && cycles < 20) begin
            @(negedge clk27);
            cycles++;
        end
        if (ack_o !== level)
            abort_run(level ? "ack_o did not rise within 20 cycles"
                            : "ack_o did not fall within 20 cycles");
    endtask

    // one four-phase transfer on the host port
    // read data and its mirror are compared with exp on reads only
    task host_xfer(input logic we, input logic addr, input ctrl_word_t wdata,
                   input ctrl_word_t exp);
        int cycles;
        @(posedge clk27);
        req_i   <= 1'b1;
        we_i    <= we;
        addr_i  <= addr;
        wdata_i <= wdata;
        wait_ack(1'b1, cycles);
        check_count++;
        if (cycles != 2) begin
            err_count++;
            $display("ack_o rose %0d cycles after req_i instead of 2", cycles);
        end
        if (!we) begin
            check_ctrl("rdata_o", rdata_o, exp);      // valid while ack is high
            check_ctrl("ack_rdata_unused_guard_o", rdata_mirror, exp);
        end
        @(posedge clk27);
        req_i <= 1'b0;
        wait_ack(1'b0, cycles);
        check_count++;
        if (cycles != 2) begin
            err_count++;
            $display("ack_o fell %0d cycles after req_i instead of 2", cycles);
        end
        if (we && !addr)
            model_sys_ctrl = wdata;
    endtask

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        int          i;
        int          cycles;
        logic [31:0] r;
        logic [31:0] t;
        ctrl_word_t  wd;
        pixel_t      pix_exp;
        logic [5:0]  flags;
        logic        strobe;

        req_i = 1'b0;
        we_i = 1'b0;
        addr_i = 1'b0;
        wdata_i = '0;
        key_i = '1;                 // buttons released
        hsync_i = 1'b0;
        vsync_i = 1'b0;
        fid_i = 1'b0;
        resync_strobe_i = 1'b0;
        pix_i = '0;
        hs_i = 1'b0;
        vs_i = 1'b0;
        de_i = 1'b0;
        osd_enable_i = 1'b0;
        osd_color_i = OSD_BLACK;
        model_sys_ctrl = '0;
        model_ctr = '0;
        strobe_hist = '0;
        err_count = 0;
        check_count = 0;
        test_count = 0;
        test_fail_count = 0;
        test_err_base = 0;

        cycles = 0;
        while (sys_reset_n !== 1'b1 && cycles < 10) begin
            @(posedge clk27);
            cycles++;
        end
        if (sys_reset_n !== 1'b1)
            abort_run("sys_reset_n was never released");
        @(negedge clk27);

        check_bit("ack_o", ack_o, 1'b0);
        check_pixel("tx_pix_o", tx_pix_o, '0);
        check_bit("tx_hs_o", tx_hs_o, 1'b0);
        check_bit("tx_vs_o", tx_vs_o, 1'b0);
        check_bit("tx_de_o", tx_de_o, 1'b0);
        check_led("led_o", led_o, led_word(1'b0, 1'b0));
        host_xfer(1'b0, 1'b1, '0, 16'h0003);
        end_test("reset values");

        for (i = 0; i < 8; i++) begin
            r = lcg_next();
            host_xfer(1'b1, 1'b0, r[31:16], '0);
            host_xfer(1'b0, 1'b0, '0, model_sys_ctrl);
        end
        host_xfer(1'b1, 1'b1, ~model_sys_ctrl, '0);   // controls word is read only
        host_xfer(1'b0, 1'b0, '0, model_sys_ctrl);
        end_test("register write and read");

        for (i = 0; i < 6; i++) begin
            r = lcg_next();
            @(posedge clk27);
            key_i <= r[17:16];
            repeat (3) @(posedge clk27);
            host_xfer(1'b0, 1'b1, '0, {{(`SCAN_CTRL_W-`SCAN_KEY_W){1'b0}}, r[17:16]});
        end
        end_test("keys in controls word");

        for (i = 0; i < 200; i++) begin
            r = lcg_next();
            t = lcg_next();
            @(posedge clk27);
            pix_i        <= r[31:8];
            hs_i         <= t[31];
            vs_i         <= t[30];
            de_i         <= t[29];
            osd_enable_i <= t[28];
            osd_color_i  <= osd_color_t'(t[27:26]);
            hsync_i      <= t[25];
            vsync_i      <= t[24];
            fid_i        <= t[23];
            pix_q.push_back(t[28] ? osd_rgb(osd_color_t'(t[27:26])) : r[31:8]);
            flag_q.push_back({t[31:29], t[25] ^ model_sys_ctrl[`SCAN_HSYNC_POL_BIT],
                              t[24] ^ model_sys_ctrl[`SCAN_VSYNC_POL_BIT], t[23]});
            @(negedge clk27);
            if (pix_q.size() == 3) begin
                pix_exp = pix_q.pop_front();
                flags   = flag_q.pop_front();
                check_pixel("tx_pix_o", tx_pix_o, pix_exp);
                check_bit("tx_hs_o", tx_hs_o, flags[5]);
                check_bit("tx_vs_o", tx_vs_o, flags[4]);
                check_bit("tx_de_o", tx_de_o, flags[3]);
                check_bit("hsync_o", hsync_o, flags[2]);
                check_bit("vsync_o", vsync_o, flags[1]);
                check_bit("fid_o", fid_o, flags[0]);
            end
        end
        pix_q.delete();
        flag_q.delete();
        end_test("osd overlay and syncs");

        r  = lcg_next();
        wd = r[31:16];
        wd[`SCAN_FRAMELOCK_BIT] = 1'b1;
        host_xfer(1'b1, 1'b0, wd, '0);
        // second edge lands while the first hold is still running
        for (i = 0; i < 1800; i++) begin
            strobe = (i >= 10 && i < 20) || (i >= 600 && i < 610);
            @(posedge clk27);
            resync_strobe_i <= strobe;
            strobe_hist = {strobe_hist[4:0], strobe};
            if (strobe_hist[4] && !strobe_hist[5])
                model_ctr = '1;
            else if (model_ctr != '0)
                model_ctr = model_ctr - 1'b1;
            @(negedge clk27);
            check_led("led_o", led_o,
                      led_word(model_sys_ctrl[`SCAN_FRAMELOCK_BIT], model_ctr != '0));
        end
        wd[`SCAN_FRAMELOCK_BIT] = 1'b0;
        host_xfer(1'b1, 1'b0, wd, '0);
        check_led("led_o", led_o, led_word(1'b0, 1'b0));
        end_test("led word");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, test_fail_count, check_count, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* scan_io.f */
+incdir+.
scan_io_pkg.sv
host_ctrl.sv
input_sync.sv
led_status.sv
osd_mixer.sv
scan_io_top.sv
tb_clock.sv
scan_io_tb.sv
